/* src/afu_cfg.svh */
// ****************************************
// Build-time sizes and constants for the AFU MMIO block
// ****************************************
`ifndef AFU_CFG_SVH
`define AFU_CFG_SVH

// Register stages in each direction between host and AFU
`define AFU_REG_STAGES 2

// Width of MMIO read and write data
`define AFU_DATA_W 64

// Value returned by a read of the identifier CSR
`define AFU_ID 64'h5a3c_91e0_7d42_b18f

`endif

/* src/host_chan_pkg.sv */
// ****************************************
// Host channel types shared by the register stage and the AFU
// ****************************************
`default_nettype none

`include "afu_cfg.svh"

package host_chan_pkg;

    // Host power-state level
    typedef logic [1:0] t_power_state;

    // MMIO transaction id, echoed back on the read response
    typedef logic [8:0] t_tid;

    // Memory response type codes
    localparam logic [3:0] RSP_TYPE_RD   = 4'h0;
    localparam logic [3:0] RSP_TYPE_WR   = 4'h1;
    localparam logic [3:0] RSP_TYPE_INTR = 4'h4;

    // MMIO request view of the channel-0 header
    typedef struct packed {
        logic [6:0]  spare;
        t_tid        tid;
        // Address in 4-byte units
        logic [15:0] address;
    } t_mmio_hdr;

    // Memory response view of the channel-0 header
    typedef struct packed {
        logic [11:0] spare;
        logic [15:0] mdata;
        logic [3:0]  resp_type;
    } t_rsp_hdr;

    // One header word, read through the view picked by the valid flag
    typedef union packed {
        t_mmio_hdr mmio;
        t_rsp_hdr  rsp;
    } t_c0_hdr;

    // Receive channel, host to AFU
    typedef struct packed {
        t_c0_hdr                 c0_hdr;
        logic [`AFU_DATA_W-1:0]  c0_data;
        logic                    mmio_rd_valid;
        logic                    mmio_wr_valid;
        logic                    rsp_valid;
    } t_host_rx;

    // Transmit channel 2, MMIO read responses to the host
    typedef struct packed {
        t_tid                    c2_tid;
        logic [`AFU_DATA_W-1:0]  c2_data;
        logic                    c2_valid;
    } t_host_tx;

endpackage

`default_nettype wire

/* src/afu_csr_pkg.sv */
// ****************************************
// AFU register map and the decoded CSR request
// ****************************************
`default_nettype none

`include "afu_cfg.svh"

package afu_csr_pkg;

    // CSR addresses in 4-byte units, 64-bit registers on even slots
    typedef enum logic [15:0] {
        CSR_ID        = 16'h0000,
        CSR_SCRATCH0  = 16'h0002,
        CSR_SCRATCH1  = 16'h0004,
        CSR_STATUS    = 16'h0006,
        CSR_RSP_COUNT = 16'h0008
    } t_csr_addr;

    // Status register bit positions
    localparam int STATUS_ERR_BIT = 0;
    localparam int STATUS_PWR_LSB = 4;

    // Request from the decoder into the CSR file
    typedef struct packed {
        logic                    rd;
        logic                    wr;
        t_csr_addr               addr;
        host_chan_pkg::t_tid     tid;
        logic [`AFU_DATA_W-1:0]  wdata;
    } t_csr_req;

endpackage

`default_nettype wire

/* src/host_chan_reg.sv */
// ****************************************
// Pipeline registers between host channel and AFU
// N_REG_STAGES of zero gives plain wires
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module host_chan_reg
#(
    parameter int N_REG_STAGES = 1
)
(
    input  logic                        clk,

    // Host to AFU
    input  host_chan_pkg::t_host_rx     rx_in,
    output host_chan_pkg::t_host_rx     rx_out,

    // AFU to host
    input  host_chan_pkg::t_host_tx     tx_in,
    output host_chan_pkg::t_host_tx     tx_out,

    // Side levels, host to AFU
    input  logic                        reset_in,
    output logic                        reset_out,
    input  logic                        error_in,
    output logic                        error_out,
    input  host_chan_pkg::t_power_state power_in,
    output host_chan_pkg::t_power_state power_out
);

    import host_chan_pkg::*;

    genvar s;

    generate
        if (N_REG_STAGES == 0)
        begin : g_wires
            assign rx_out    = rx_in;
            assign tx_out    = tx_in;
            assign reset_out = reset_in;
            assign error_out = error_in;
            assign power_out = power_in;
        end
        else
        begin : g_stages
            // Reset chain powers up asserted
            // so the AFU side holds in reset until the host reset propagates
            logic [N_REG_STAGES-1:0] reset_q = '1;

            t_host_rx     rx_q    [N_REG_STAGES];
            t_host_tx     tx_q    [N_REG_STAGES];
            logic         error_q [N_REG_STAGES];
            t_power_state power_q [N_REG_STAGES];

            // First stage takes the inputs
            always_ff @(posedge clk)
            begin
                reset_q[0] <= reset_in;
                rx_q[0]    <= rx_in;
                tx_q[0]    <= tx_in;
                error_q[0] <= error_in;
                power_q[0] <= power_in;
            end

            // Remaining stages shift by one each cycle
            for (s = 1; s < N_REG_STAGES; s = s + 1)
            begin : g_shift
                always_ff @(posedge clk)
                begin
                    reset_q[s] <= reset_q[s-1];
                    rx_q[s]    <= rx_q[s-1];
                    tx_q[s]    <= tx_q[s-1];
                    error_q[s] <= error_q[s-1];
                    power_q[s] <= power_q[s-1];
                end
            end

            // Last stage drives the far side
            assign reset_out = reset_q[N_REG_STAGES-1];
            assign rx_out    = rx_q[N_REG_STAGES-1];
            assign tx_out    = tx_q[N_REG_STAGES-1];
            assign error_out = error_q[N_REG_STAGES-1];
            assign power_out = power_q[N_REG_STAGES-1];
        end
    endgenerate

endmodule

`default_nettype wire

/* src/mmio_decode.sv */
// ****************************************
// Splits receive channel 0 into CSR requests and response events
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module mmio_decode
(
    input  logic                    clk,
    input  logic                    reset,

    // Receive channel on the AFU side of the register stage
    input  host_chan_pkg::t_host_rx rx,

    // Decoded MMIO request one cycle after rx
    output afu_csr_pkg::t_csr_req   csr_req,

    // One pulse per memory read response
    output logic                    rsp_event
);

    import host_chan_pkg::*;
    import afu_csr_pkg::*;

    logic mmio_valid;
    logic rd_rsp;

    // Either MMIO flag selects the request view of the header
    assign mmio_valid = rx.mmio_rd_valid || rx.mmio_wr_valid;

    // Response view counts only read responses
    assign rd_rsp = rx.rsp_valid && (rx.c0_hdr.rsp.resp_type == RSP_TYPE_RD);

    always_ff @(posedge clk)
    begin
        // Payload follows the request
        if (mmio_valid)
        begin
            // Addresses off the map pass through and read as zero later
            csr_req.addr <= t_csr_addr'(rx.c0_hdr.mmio.address);
            csr_req.tid  <= rx.c0_hdr.mmio.tid;
        end

        // Write data only on writes
        if (rx.mmio_wr_valid)
        begin
            csr_req.wdata <= rx.c0_data;
        end

        // Strobes
        if (reset)
        begin
            csr_req.rd <= 1'b0;
            csr_req.wr <= 1'b0;
            rsp_event  <= 1'b0;
        end
        else
        begin
            csr_req.rd <= rx.mmio_rd_valid;
            csr_req.wr <= rx.mmio_wr_valid;
            rsp_event  <= rd_rsp;
        end
    end

endmodule

`default_nettype wire

/* src/csr_file.sv */
// ****************************************
// AFU control and status registers
// Answers MMIO reads on transmit channel 2 one cycle after the request
// ****************************************
`timescale 1ns/1ns
`default_nettype none

`include "afu_cfg.svh"

module csr_file
(
    input  logic                        clk,
    input  logic                        reset,

    // Decoded MMIO request
    input  afu_csr_pkg::t_csr_req       csr_req,

    // Memory read response pulse
    input  logic                        rsp_event,

    // Host levels after the register stage
    input  logic                        error,
    input  host_chan_pkg::t_power_state power,

    // Read responses
    output host_chan_pkg::t_host_tx     tx
);

    import host_chan_pkg::*;
    import afu_csr_pkg::*;

    // Register state
    logic [`AFU_DATA_W-1:0] scratch0;
    logic [`AFU_DATA_W-1:0] scratch1;
    logic [`AFU_DATA_W-1:0] rsp_count;
    logic                   err_q;

    // Write-1 to status bit 0 clears the error
    logic                   err_clr;

    // Read mux output
    logic [`AFU_DATA_W-1:0] rd_data;
    logic [`AFU_DATA_W-1:0] status;

    assign err_clr = csr_req.wr && (csr_req.addr == CSR_STATUS) &&
                     csr_req.wdata[STATUS_ERR_BIT];

    // Status word: sticky error and power state
    always_comb
    begin
        status = '0;
        status[STATUS_ERR_BIT] = err_q;
        status[STATUS_PWR_LSB +: 2] = power;
    end

    // Read mux, unmapped addresses give zero
    always_comb
    begin
        case (csr_req.addr)
            CSR_ID:        rd_data = `AFU_ID;
            CSR_SCRATCH0:  rd_data = scratch0;
            CSR_SCRATCH1:  rd_data = scratch1;
            CSR_STATUS:    rd_data = status;
            CSR_RSP_COUNT: rd_data = rsp_count;
            default:       rd_data = '0;
        endcase
    end

    // Writable registers update at the request edge
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            scratch0 <= '0;
            scratch1 <= '0;
        end
        else if (csr_req.wr)
        begin
            // ID, status and count ignore data writes
            if (csr_req.addr == CSR_SCRATCH0)
                scratch0 <= csr_req.wdata;
            if (csr_req.addr == CSR_SCRATCH1)
                scratch1 <= csr_req.wdata;
        end
    end

    // Sticky error and response counter
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            err_q     <= 1'b0;
            rsp_count <= '0;
        end
        else
        begin
            // A live error level wins over a clear
            if (error)
                err_q <= 1'b1;
            else if (err_clr)
                err_q <= 1'b0;

            if (rsp_event)
                rsp_count <= rsp_count + 1'b1;
        end
    end

    // Registered read response
    always_ff @(posedge clk)
    begin
        tx.c2_tid  <= csr_req.tid;
        tx.c2_data <= rd_data;

        if (reset)
            tx.c2_valid <= 1'b0;
        else
            tx.c2_valid <= csr_req.rd;
    end

endmodule

`default_nettype wire

/* src/afu_top.sv */
// ****************************************
// AFU MMIO top: host register stage, decoder and CSR file
// ****************************************
`timescale 1ns/1ns
`default_nettype none

`include "afu_cfg.svh"

module afu_top
(
    input  logic                        clk,

    // Host side
    input  logic                        host_reset,
    input  host_chan_pkg::t_host_rx     host_rx,
    input  logic                        host_error,
    input  host_chan_pkg::t_power_state host_power,
    output host_chan_pkg::t_host_tx     host_tx
);

    import host_chan_pkg::*;
    import afu_csr_pkg::*;

    // AFU side of the register stage
    t_host_rx     afu_rx;
    t_host_tx     afu_tx;
    logic         afu_reset;
    logic         afu_error;
    t_power_state afu_power;

    // Decoder to CSR file
    t_csr_req     csr_req;
    logic         rsp_event;

    // N stages each way, read latency 2N+2 overall
    host_chan_reg
    #(
        .N_REG_STAGES (`AFU_REG_STAGES)
    )
    u_chan_reg
    (
        .clk       (clk),
        .rx_in     (host_rx),
        .rx_out    (afu_rx),
        .tx_in     (afu_tx),
        .tx_out    (host_tx),
        .reset_in  (host_reset),
        .reset_out (afu_reset),
        .error_in  (host_error),
        .error_out (afu_error),
        .power_in  (host_power),
        .power_out (afu_power)
    );

    mmio_decode u_decode
    (
        .clk       (clk),
        .reset     (afu_reset),
        .rx        (afu_rx),
        .csr_req   (csr_req),
        .rsp_event (rsp_event)
    );

    csr_file u_csr
    (
        .clk       (clk),
        .reset     (afu_reset),
        .csr_req   (csr_req),
        .rsp_event (rsp_event),
        .error     (afu_error),
        .power     (afu_power),
        .tx        (afu_tx)
    );

endmodule

`default_nettype wire

/* test/tb_afu_top.sv */
// ****************************************
// Directed testbench for the AFU MMIO top
// Drives the host side and checks channel-2 read responses
// ****************************************
`timescale 1ns/1ns
`default_nettype none

`include "afu_cfg.svh"

module tb_afu_top;

    import host_chan_pkg::*;
    import afu_csr_pkg::*;

    // Read issue to host_tx c2_valid
    localparam int READ_LAT   = 2 * `AFU_REG_STAGES + 2;
    // About 25 reads of 8 cycles each plus writes, well under the limit
    localparam int MAX_CYCLES = 2000;

    logic         clk;
    logic         host_reset;
    t_host_rx     host_rx;
    logic         host_error;
    t_power_state host_power;
    t_host_tx     host_tx;

    logic [31:0]  lcg_state   = 32'hebe9;
    int           cycle_count = 0;

    afu_top u_dut
    (
        .clk        (clk),
        .host_reset (host_reset),
        .host_rx    (host_rx),
        .host_error (host_error),
        .host_power (host_power),
        .host_tx    (host_tx)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // Run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    // LCG for data, tids and response types
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    task automatic report_mismatch(input string test, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("MISMATCH %s: expected %h, actual %h", test, exp, act);
        $display("TEST FAIL");
        $fatal(1, "Check failed in %s", test);
    endtask

    // MMIO request view of the header
    function automatic t_c0_hdr mmio_hdr(input logic [15:0] addr, input t_tid tid);
        t_c0_hdr h;
        h = '0;
        h.mmio.address = addr;
        h.mmio.tid     = tid;
        return h;
    endfunction

    task automatic send_read(input logic [15:0] addr, input t_tid tid);
        @(posedge clk);
        host_rx.c0_hdr        <= mmio_hdr(addr, tid);
        host_rx.mmio_rd_valid <= 1'b1;
        host_rx.mmio_wr_valid <= 1'b0;
        host_rx.rsp_valid     <= 1'b0;
    endtask

    task automatic send_write(input logic [15:0] addr, input logic [63:0] data);
        @(posedge clk);
        host_rx.c0_hdr        <= mmio_hdr(addr, 9'h0);
        host_rx.c0_data       <= data;
        host_rx.mmio_rd_valid <= 1'b0;
        host_rx.mmio_wr_valid <= 1'b1;
        host_rx.rsp_valid     <= 1'b0;
    endtask

    // Memory response with a random mdata tag
    task automatic send_rsp(input logic [3:0] rtype);
        t_c0_hdr     h;
        logic [31:0] r;
        r = next_rand();
        h = '0;
        h.rsp.resp_type = rtype;
        h.rsp.mdata     = r[15:0];
        @(posedge clk);
        host_rx.c0_hdr        <= h;
        host_rx.mmio_rd_valid <= 1'b0;
        host_rx.mmio_wr_valid <= 1'b0;
        host_rx.rsp_valid     <= 1'b1;
    endtask

    task automatic send_idle();
        @(posedge clk);
        host_rx.mmio_rd_valid <= 1'b0;
        host_rx.mmio_wr_valid <= 1'b0;
        host_rx.rsp_valid     <= 1'b0;
    endtask

    // Outputs sampled at the falling edge, half a cycle after they change
    task automatic check_quiet(input string test);
        @(negedge clk);
        assert (!host_tx.c2_valid)
        else report_mismatch({test, " valid"}, 64'd0, 64'(host_tx.c2_valid));
    endtask

    task automatic check_rsp(input string test, input t_tid tid, input logic [63:0] exp);
        @(negedge clk);
        assert (host_tx.c2_valid)
        else report_mismatch({test, " valid"}, 64'd1, 64'(host_tx.c2_valid));
        assert (host_tx.c2_tid == tid)
        else report_mismatch({test, " tid"}, 64'(tid), 64'(host_tx.c2_tid));
        assert (host_tx.c2_data == exp)
        else report_mismatch(test, exp, host_tx.c2_data);
    endtask

    // One read, response checked exactly READ_LAT cycles after issue
    task automatic read_check(input string test, input logic [15:0] addr,
                              input logic [63:0] exp);
        t_tid tid;
        tid = t_tid'(next_rand());
        send_read(addr, tid);
        send_idle();
        repeat (READ_LAT - 2) @(posedge clk);
        check_quiet(test);
        @(posedge clk);
        check_rsp(test, tid, exp);
    endtask

    task automatic test_id();
        // Nothing comes back while idle
        repeat (8) check_quiet("test_id idle");
        read_check("test_id", CSR_ID, `AFU_ID);
    endtask

    task automatic test_scratch();
        logic [63:0] d0;
        logic [63:0] d1;
        t_tid        tid_a;
        t_tid        tid_b;
        for (int i = 0; i < 4; i++)
        begin
            d0 = rand_word();
            d1 = rand_word();
            send_write(CSR_SCRATCH0, d0);
            send_write(CSR_SCRATCH1, d1);
            read_check("test_scratch s0", CSR_SCRATCH0, d0);
            read_check("test_scratch s1", CSR_SCRATCH1, d1);
        end
        // Two reads on consecutive cycles, answered in order
        tid_a = t_tid'(next_rand());
        tid_b = tid_a + 9'd1;
        send_read(CSR_SCRATCH1, tid_a);
        send_read(CSR_SCRATCH0, tid_b);
        send_idle();
        repeat (READ_LAT - 3) @(posedge clk);
        check_quiet("test_scratch b2b");
        @(posedge clk);
        check_rsp("test_scratch b2b first", tid_a, d1);
        @(posedge clk);
        check_rsp("test_scratch b2b second", tid_b, d0);
        check_quiet("test_scratch b2b after");
    endtask

    task automatic test_status();
        t_power_state pwr;
        pwr = t_power_state'(next_rand());
        @(posedge clk);
        host_power <= pwr;
        host_error <= 1'b1;
        @(posedge clk);
        host_error <= 1'b0;
        // Error bit 0, power in 5:4
        read_check("test_status set", CSR_STATUS, {58'd0, pwr, 3'd0, 1'b1});
        read_check("test_status sticky", CSR_STATUS, {58'd0, pwr, 3'd0, 1'b1});
        send_write(CSR_STATUS, 64'h1);
        read_check("test_status clear", CSR_STATUS, {58'd0, pwr, 4'd0});
        pwr = ~pwr;
        @(posedge clk);
        host_power <= pwr;
        read_check("test_status power", CSR_STATUS, {58'd0, pwr, 4'd0});
    endtask

    task automatic test_rsp_count();
        logic [31:0] r;
        int          n_rd;
        n_rd = 0;
        read_check("test_rsp_count start", CSR_RSP_COUNT, 64'd0);
        for (int i = 0; i < 16; i++)
        begin
            r = next_rand();
            // Half read responses, the rest write or interrupt
            if (r[9] == 1'b0)
            begin
                send_rsp(RSP_TYPE_RD);
                n_rd++;
            end
            else if (r[8] == 1'b0)
                send_rsp(RSP_TYPE_WR);
            else
                send_rsp(RSP_TYPE_INTR);
        end
        read_check("test_rsp_count", CSR_RSP_COUNT, 64'(n_rd));
    endtask

    task automatic test_unmapped();
        read_check("test_unmapped 0x3", 16'h0003, 64'd0);
        read_check("test_unmapped 0xa", 16'h000a, 64'd0);
        read_check("test_unmapped 0x1000", 16'h1000, 64'd0);
        // ID is read-only
        send_write(CSR_ID, rand_word());
        read_check("test_unmapped id write", CSR_ID, `AFU_ID);
    endtask

    initial
    begin
        clk        = 1'b0;
        host_reset = 1'b1;
        host_rx    = '0;
        host_error = 1'b0;
        host_power = '0;
        // Reset for 2 cycles, then let it drain through the stages
        repeat (2) @(posedge clk);
        host_reset <= 1'b0;
        repeat (READ_LAT) @(posedge clk);

        test_id();
        test_scratch();
        test_status();
        test_rsp_count();
        test_unmapped();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/host_chan_pkg.sv
src/afu_csr_pkg.sv
src/host_chan_reg.sv
src/mmio_decode.sv
src/csr_file.sv
src/afu_top.sv
test/tb_afu_top.sv

/* run.sh */
#!/bin/sh
# Build and run the AFU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_afu_top -o tb_afu_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_afu_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

exit 0
